// ==== tb.f ====
hdl/follow_pkg.sv
hdl/ir_nec_rx.sv
hdl/remote_settings.sv
hdl/stun_timer.sv
hdl/drive_decider.sv
hdl/follow_bot_top.sv
testbench/tb_follow_bot.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the follow bot testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_follow_bot -f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_follow_bot
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// ==== testbench/tb_follow_bot.sv ====
`timescale 1ns/1ps

module tb_follow_bot
	import follow_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int GAP_UNITS = 20;
	// Longest frame is all ones, followed by the idle gap.
	localparam int FRAME_CYCLES = (16 + 8 + 32 * 4 + 1 + GAP_UNITS) * IR_UNIT_CYCLES;
	localparam int FRAME_COUNT = 40;
	localparam int WATCHDOG_CYCLES = FRAME_COUNT * FRAME_CYCLES + 4 * STUN_CYCLES + 2000;

	logic                   clk;
	logic                   rst_n;
	logic                   no_red;
	logic [PIX_BITS-1:0]    pixel_count;
	logic [DIR_BITS-1:0]    direction;
	logic [DIST_BITS-1:0]   average_distance;
	logic [AMP_BITS-1:0]    amplitude;
	logic                   ir_rx;
	logic [CMD_BITS-1:0]    drive_command;
	logic [FOLLOW_BITS-1:0] follow_distance;
	logic [MULT_BITS-1:0]   multiplier;

	// Reference settings.
	bit         off_m;
	bit         mute_m;
	int         dist_m;
	logic [7:0] last_m;

	follow_bot_top DUT (
		.clk              (clk),
		.rst_n            (rst_n),
		.no_red           (no_red),
		.pixel_count      (pixel_count),
		.direction        (direction),
		.average_distance (average_distance),
		.amplitude        (amplitude),
		.ir_rx            (ir_rx),
		.drive_command    (drive_command),
		.follow_distance  (follow_distance),
		.multiplier       (multiplier)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("error: watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			$display("error at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
			$display("TESTS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic int steer_for(input int d);
		if (d < int'(LEFT_BOUND)) begin
			return int'(CMD_LEFT);
		end
		if (d > int'(RIGHT_BOUND)) begin
			return int'(CMD_RIGHT);
		end
		return int'(CMD_STRAIGHT);
	endfunction

	// Stun is not part of this; stun checks give their own value.
	function automatic int expected_cmd();
		if (no_red || int'(average_distance) < dist_m || off_m) begin
			return int'(CMD_STOP);
		end
		return steer_for(int'(direction));
	endfunction

	// A loud sample stops the robot unless muted.
	function automatic int loud_cmd();
		if (mute_m) begin
			return expected_cmd();
		end
		return int'(CMD_STOP);
	endfunction

	function automatic int mult_rule(input int p);
		if (p > int'(PIX_HIGH)) begin
			return 3;
		end
		if (p > int'(PIX_MED)) begin
			return 2;
		end
		return 1;
	endfunction

	task automatic apply_key(input logic [7:0] k);
		case (k)
			KEY_POWER: off_m = 1'b1;
			KEY_PLAY: off_m = 1'b0;
			KEY_MUTE: mute_m = 1'b1;
			KEY_RETURN: begin
				mute_m = 1'b0;
				dist_m = 20;
			end
			KEY_UP: if (k != last_m && dist_m < 100) dist_m = dist_m + 10;
			KEY_DOWN: if (k != last_m && dist_m > 20) dist_m = dist_m - 10;
			default: ;
		endcase
		last_m = k;
	endtask

	task automatic settle();
		repeat (3) @(posedge clk);
	endtask

	task automatic check_cmd(input int expected);
		settle();
		@(negedge clk);
		check_value("drive_command", int'(drive_command), expected);
	endtask

	task automatic check_settings();
		settle();
		@(negedge clk);
		check_value("follow_distance", int'(follow_distance), dist_m);
		check_value("drive_command", int'(drive_command), expected_cmd());
	endtask

	task automatic hold_line(input logic lvl, input int units);
		ir_rx <= lvl;
		repeat (units * IR_UNIT_CYCLES) @(posedge clk);
	endtask

	task automatic send_frame(input logic [15:0] addr, input logic [7:0] cmd,
			input logic [7:0] inv);
		nec_frame_u f;
		f.fields.address = addr;
		f.fields.command = cmd;
		f.fields.command_inv = inv;
		@(posedge clk);
		hold_line(1'b0, 16);
		hold_line(1'b1, 8);
		// LSB first, long space is a one.
		for (int i = 0; i < 32; i++) begin
			hold_line(1'b0, 1);
			hold_line(1'b1, f.raw[i] ? 3 : 1);
		end
		hold_line(1'b0, 1);
		hold_line(1'b1, GAP_UNITS);
	endtask

	task automatic press_key(input logic [7:0] k);
		send_frame(REMOTE_ADDR, k, ~k);
		apply_key(k);
		check_settings();
	endtask

	task automatic loud_sample();
		@(posedge clk);
		amplitude <= AMP_BITS'(100);
		@(posedge clk);
		amplitude <= '0;
	endtask

	task automatic check_mult(input int p, input int expected);
		@(posedge clk);
		pixel_count <= PIX_BITS'(p);
		@(negedge clk);
		check_value("multiplier", int'(multiplier), expected);
	endtask

	task automatic test_steering();
		int d;
		@(negedge clk);
		check_value("follow_distance", int'(follow_distance), 20);
		check_value("drive_command", int'(drive_command), int'(CMD_STOP));
		for (int i = 0; i < 40; i++) begin
			d = int'($urandom_range(25, 0));
			@(posedge clk);
			direction <= DIR_BITS'(d);
			check_cmd(steer_for(d));
		end
		@(posedge clk);
		no_red <= 1'b1;
		check_cmd(int'(CMD_STOP));
		@(posedge clk);
		no_red <= 1'b0;
		direction <= DIR_BITS'(12);
		check_cmd(int'(CMD_STRAIGHT));
	endtask

	task automatic test_distance();
		@(posedge clk);
		average_distance <= DIST_BITS'(dist_m - 1);
		check_cmd(int'(CMD_STOP));
		@(posedge clk);
		average_distance <= DIST_BITS'(dist_m);
		check_cmd(int'(CMD_STRAIGHT));
		@(posedge clk);
		average_distance <= DIST_BITS'(200);
		check_cmd(int'(CMD_STRAIGHT));
	endtask

	task automatic test_power_keys();
		press_key(KEY_POWER);
		check_value("drive_command", int'(drive_command), int'(CMD_STOP));
		press_key(KEY_PLAY);
		send_frame(REMOTE_ADDR ^ 16'h0001, KEY_POWER, ~KEY_POWER);
		check_settings();
		send_frame(REMOTE_ADDR, KEY_POWER, KEY_POWER);
		check_settings();
		check_value("drive_command", int'(drive_command), int'(CMD_STRAIGHT));
	endtask

	task automatic test_follow_distance();
		for (int i = 0; i < 9; i++) begin
			press_key(KEY_UP);
			press_key(KEY_PLAY);
		end
		check_value("follow_distance", int'(follow_distance), 100);
		press_key(KEY_RETURN);
		press_key(KEY_UP);
		press_key(KEY_UP);
		check_value("follow_distance", int'(follow_distance), 30);
		press_key(KEY_DOWN);
		press_key(KEY_PLAY);
		press_key(KEY_DOWN);
		check_value("follow_distance", int'(follow_distance), 20);
		press_key(KEY_UP);
		press_key(KEY_RETURN);
		check_value("follow_distance", int'(follow_distance), 20);
	endtask

	task automatic test_stun_mute();
		loud_sample();
		repeat (STUN_CYCLES - 5) @(posedge clk);
		@(negedge clk);
		check_value("drive_command", int'(drive_command), int'(CMD_STOP));
		repeat (10) @(posedge clk);
		@(negedge clk);
		check_value("drive_command", int'(drive_command), int'(CMD_STRAIGHT));
		press_key(KEY_MUTE);
		loud_sample();
		check_cmd(loud_cmd());
		press_key(KEY_RETURN);
		loud_sample();
		check_cmd(loud_cmd());
		repeat (STUN_CYCLES + 5) @(posedge clk);
		check_cmd(int'(CMD_STRAIGHT));
	endtask

	task automatic test_multiplier();
		int p;
		check_mult(0, 1);
		check_mult(5000, 1);
		check_mult(5001, 2);
		check_mult(15000, 2);
		check_mult(15001, 3);
		for (int i = 0; i < 20; i++) begin
			p = int'($urandom_range(IMAGE_WIDTH * IMAGE_HEIGHT - 1, 0));
			check_mult(p, mult_rule(p));
		end
	endtask

	initial begin
		void'($urandom(8));
		rst_n = 1'b0;
		no_red = 1'b0;
		pixel_count = '0;
		direction = DIR_BITS'(12);
		average_distance = DIST_BITS'(200);
		amplitude = '0;
		ir_rx = 1'b1;
		off_m = 1'b0;
		mute_m = 1'b0;
		dist_m = 20;
		last_m = 8'h00;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		test_steering();
		test_distance();
		test_power_keys();
		test_follow_distance();
		test_stun_mute();
		test_multiplier();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== hdl/follow_bot_top.sv ====
`timescale 1ns/1ps

module follow_bot_top
	import follow_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   no_red,
	input  logic [PIX_BITS-1:0]    pixel_count,
	input  logic [DIR_BITS-1:0]    direction,
	input  logic [DIST_BITS-1:0]   average_distance,
	input  logic [AMP_BITS-1:0]    amplitude,
	input  logic                   ir_rx,
	output logic [CMD_BITS-1:0]    drive_command,
	output logic [FOLLOW_BITS-1:0] follow_distance,
	output logic [MULT_BITS-1:0]   multiplier
);

	logic [7:0] key;
	logic       key_valid;
	logic       bot_off;
	logic       mute;
	logic       stun;

	ir_nec_rx u_ir_nec_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.ir_rx     (ir_rx),
		.key       (key),
		.key_valid (key_valid)
	);

	remote_settings u_remote_settings (
		.clk             (clk),
		.rst_n           (rst_n),
		.key             (key),
		.key_valid       (key_valid),
		.bot_off         (bot_off),
		.mute            (mute),
		.follow_distance (follow_distance)
	);

	stun_timer u_stun_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.amplitude (amplitude),
		.mute      (mute),
		.stun      (stun)
	);

	drive_decider u_drive_decider (
		.clk              (clk),
		.rst_n            (rst_n),
		.no_red           (no_red),
		.direction        (direction),
		.average_distance (average_distance),
		.follow_distance  (follow_distance),
		.bot_off          (bot_off),
		.stun             (stun),
		.pixel_count      (pixel_count),
		.drive_command    (drive_command),
		.multiplier       (multiplier)
	);

endmodule

// ==== hdl/drive_decider.sv ====
`timescale 1ns/1ps

module drive_decider
	import follow_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   no_red,
	input  logic [DIR_BITS-1:0]    direction,
	input  logic [DIST_BITS-1:0]   average_distance,
	input  logic [FOLLOW_BITS-1:0] follow_distance,
	input  logic                   bot_off,
	input  logic                   stun,
	input  logic [PIX_BITS-1:0]    pixel_count,
	output logic [CMD_BITS-1:0]    drive_command,
	output logic [MULT_BITS-1:0]   multiplier
);

	logic                too_close;
	logic [CMD_BITS-1:0] next_cmd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			too_close <= 1'b0;
		end else begin
			too_close <= average_distance < {1'b0, follow_distance};
		end
	end

	// Any safety condition wins over steering.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			next_cmd <= CMD_STOP;
		end else if (no_red || too_close || bot_off || stun) begin
			next_cmd <= CMD_STOP;
		end else if (direction < LEFT_BOUND) begin
			next_cmd <= CMD_LEFT;
		end else if (direction > RIGHT_BOUND) begin
			next_cmd <= CMD_RIGHT;
		end else begin
			next_cmd <= CMD_STRAIGHT;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive_command <= CMD_STOP;
		end else begin
			drive_command <= next_cmd;
		end
	end

	// Bigger target means more speed.
	always_comb begin
		if (pixel_count > PIX_HIGH) begin
			multiplier = MULT_BITS'(3);
		end else if (pixel_count > PIX_MED) begin
			multiplier = MULT_BITS'(2);
		end else begin
			multiplier = MULT_BITS'(1);
		end
	end

endmodule

// ==== hdl/stun_timer.sv ====
`timescale 1ns/1ps

module stun_timer
	import follow_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic [AMP_BITS-1:0] amplitude,
	input  logic                mute,
	output logic                stun
);

	logic [STUN_BITS-1:0] count;
	logic                 loud;

	assign loud = amplitude > AMP_LOUD;

	// Each loud sample restarts the hold time.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (mute) begin
			count <= '0;
		end else if (loud) begin
			count <= STUN_BITS'(STUN_CYCLES);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Mute drops stun in the same cycle.
	assign stun = (count != '0) && !mute;

endmodule

// ==== hdl/remote_settings.sv ====
`timescale 1ns/1ps

module remote_settings
	import follow_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [7:0]             key,
	input  logic                   key_valid,
	output logic                   bot_off,
	output logic                   mute,
	output logic [FOLLOW_BITS-1:0] follow_distance
);

	logic [7:0]             last_key;
	logic                   new_press;
	logic [FOLLOW_BITS-1:0] dist_up;
	logic [FOLLOW_BITS-1:0] dist_down;

	// Held keys repeat the same code, so only a change counts as a press.
	assign new_press = key != last_key;

	always_comb begin
		dist_up = follow_distance;
		dist_down = follow_distance;
		if (new_press && follow_distance < FOLLOW_MAX) begin
			dist_up = follow_distance + FOLLOW_STEP;
		end
		if (new_press && follow_distance > FOLLOW_MIN) begin
			dist_down = follow_distance - FOLLOW_STEP;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bot_off <= 1'b0;
			mute <= 1'b0;
			follow_distance <= FOLLOW_DEFAULT;
			last_key <= '0;
		end else if (key_valid) begin
			last_key <= key;
			case (key)
				KEY_POWER: bot_off <= 1'b1;
				KEY_PLAY: bot_off <= 1'b0;
				KEY_MUTE: mute <= 1'b1;
				KEY_RETURN: begin
					// Back to defaults.
					mute <= 1'b0;
					follow_distance <= FOLLOW_DEFAULT;
				end
				KEY_UP: follow_distance <= dist_up;
				KEY_DOWN: follow_distance <= dist_down;
				default: begin
					// Other keys only update last_key.
				end
			endcase
		end
	end

endmodule

// ==== hdl/ir_nec_rx.sv ====
`timescale 1ns/1ps

module ir_nec_rx
	import follow_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ir_rx,
	output logic [7:0] key,
	output logic       key_valid
);

	logic                     ir_meta;
	logic                     ir_sync;
	logic                     ir_last;
	logic                     edge_seen;
	logic                     rise;
	logic [IR_CNT_BITS-1:0]   cnt;
	logic [IR_STATE_BITS-1:0] state;
	logic [4:0]               bit_cnt;
	nec_frame_u               frame;
	logic                     frame_ok;

	// Line idles high.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir_meta <= 1'b1;
			ir_sync <= 1'b1;
			ir_last <= 1'b1;
		end else begin
			ir_meta <= ir_rx;
			ir_sync <= ir_meta;
			ir_last <= ir_sync;
		end
	end

	assign edge_seen = ir_sync != ir_last;
	assign rise = ir_sync && !ir_last;

	// Length of the current level in clocks, saturating.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (edge_seen) begin
			cnt <= IR_CNT_BITS'(1);
		end else if (cnt != '1) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign frame_ok = (frame.fields.address == REMOTE_ADDR) &&
		(frame.fields.command_inv == ~frame.fields.command);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IR_IDLE;
			bit_cnt <= '0;
			key_valid <= 1'b0;
		end else begin
			key_valid <= 1'b0;
			if (edge_seen) begin
				case (state)
					IR_IDLE: begin
						if (!ir_sync) begin
							state <= IR_LEAD_MARK;
						end
					end
					IR_LEAD_MARK: begin
						if (cnt >= IR_LEAD_MARK_MIN_CYC && cnt <= IR_LEAD_MARK_MAX_CYC) begin
							state <= IR_LEAD_SPACE;
						end else begin
							state <= IR_IDLE;
						end
					end
					IR_LEAD_SPACE: begin
						bit_cnt <= '0;
						if (cnt >= IR_LEAD_SPACE_MIN_CYC && cnt <= IR_LEAD_SPACE_MAX_CYC) begin
							state <= IR_BIT_MARK;
						end else begin
							state <= IR_IDLE;
						end
					end
					IR_BIT_MARK: state <= IR_BIT_SPACE;
					IR_BIT_SPACE: begin
						bit_cnt <= bit_cnt + 1'b1;
						state <= (bit_cnt == 5'd31) ? IR_STOP : IR_BIT_MARK;
					end
					IR_STOP: begin
						// Rising edge closes the stop mark.
						key_valid <= frame_ok;
						state <= IR_IDLE;
					end
					default: state <= IR_IDLE;
				endcase
			end else if (state != IR_IDLE && ir_sync && cnt >= IR_IDLE_CYC) begin
				state <= IR_IDLE;
			end
		end
	end

	// A long space before the falling edge is a one.
	always_ff @(posedge clk) begin
		if (edge_seen && !ir_sync && state == IR_BIT_SPACE) begin
			frame.raw <= {(cnt > IR_ONE_CYC), frame.raw[31:1]};
		end
		if (rise && state == IR_STOP && frame_ok) begin
			key <= frame.fields.command;
		end
	end

endmodule

// ==== hdl/follow_pkg.sv ====
package follow_pkg;

	// Camera image and direction index.
	localparam int IMAGE_WIDTH = 320;
	localparam int IMAGE_HEIGHT = 240;
	localparam int PIX_BITS = $clog2(IMAGE_WIDTH * IMAGE_HEIGHT);
	localparam int FOV = 25;
	localparam int DIR_BITS = $clog2(FOV) + 1;
	localparam logic [DIR_BITS-1:0] LEFT_BOUND = 6'd8;
	localparam logic [DIR_BITS-1:0] RIGHT_BOUND = 6'd15;
	localparam logic [PIX_BITS-1:0] PIX_MED = 17'd5000;
	localparam logic [PIX_BITS-1:0] PIX_HIGH = 17'd15000;
	localparam int MULT_BITS = 3;

	localparam int DIST_BITS = 8;
	localparam int FOLLOW_BITS = 7;
	localparam logic [FOLLOW_BITS-1:0] FOLLOW_DEFAULT = 7'd20;
	localparam logic [FOLLOW_BITS-1:0] FOLLOW_MIN = 7'd20;
	localparam logic [FOLLOW_BITS-1:0] FOLLOW_MAX = 7'd100;
	localparam logic [FOLLOW_BITS-1:0] FOLLOW_STEP = 7'd10;

	localparam int AMP_BITS = 11;
	localparam logic [AMP_BITS-1:0] AMP_LOUD = 11'd50;
	localparam int STUN_CYCLES = 2000;
	localparam int STUN_BITS = $clog2(STUN_CYCLES + 1);

	// NEC timing, scaled. One unit stands for 562.5 us.
	localparam int IR_UNIT_CYCLES = 8;
	localparam int IR_CNT_BITS = $clog2(32 * IR_UNIT_CYCLES);
	localparam int IR_LEAD_MARK_MIN_CYC = 12 * IR_UNIT_CYCLES;
	localparam int IR_LEAD_MARK_MAX_CYC = 20 * IR_UNIT_CYCLES;
	localparam int IR_LEAD_SPACE_MIN_CYC = 6 * IR_UNIT_CYCLES;
	localparam int IR_LEAD_SPACE_MAX_CYC = 10 * IR_UNIT_CYCLES;
	localparam int IR_ONE_CYC = 2 * IR_UNIT_CYCLES;
	localparam int IR_IDLE_CYC = 16 * IR_UNIT_CYCLES;

	localparam int IR_STATE_BITS = 3;
	localparam logic [IR_STATE_BITS-1:0] IR_IDLE = 3'd0;
	localparam logic [IR_STATE_BITS-1:0] IR_LEAD_MARK = 3'd1;
	localparam logic [IR_STATE_BITS-1:0] IR_LEAD_SPACE = 3'd2;
	localparam logic [IR_STATE_BITS-1:0] IR_BIT_MARK = 3'd3;
	localparam logic [IR_STATE_BITS-1:0] IR_BIT_SPACE = 3'd4;
	localparam logic [IR_STATE_BITS-1:0] IR_STOP = 3'd5;

	localparam logic [15:0] REMOTE_ADDR = 16'h6b86;
	localparam logic [7:0] KEY_POWER = 8'h12;
	localparam logic [7:0] KEY_PLAY = 8'h16;
	localparam logic [7:0] KEY_MUTE = 8'h0c;
	localparam logic [7:0] KEY_RETURN = 8'h17;
	localparam logic [7:0] KEY_UP = 8'h1a;
	localparam logic [7:0] KEY_DOWN = 8'h1e;

	// Drive codes. 1 and 5 are kept free for fast turns.
	localparam int CMD_BITS = 3;
	localparam logic [CMD_BITS-1:0] CMD_STOP = 3'd0;
	localparam logic [CMD_BITS-1:0] CMD_LEFT = 3'd2;
	localparam logic [CMD_BITS-1:0] CMD_STRAIGHT = 3'd3;
	localparam logic [CMD_BITS-1:0] CMD_RIGHT = 3'd4;

	// NEC frame, shifted in LSB first so the address lands in the low bits.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [7:0]  command_inv;
			logic [7:0]  command;
			logic [15:0] address;
		} fields;
	} nec_frame_u;

endpackage
